// File: design/uop_pkg.sv
package uop_pkg;

    typedef enum logic [1:0] {
        ITYPE_ALU = 2'd0,
        ITYPE_BR  = 2'd1,
        ITYPE_DIV = 2'd2
    } itype_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_t;

    // same codes as the decode stage emits
    typedef enum logic [3:0] {
        BR_JIRL = 4'd3,
        BR_B    = 4'd4,
        BR_BL   = 4'd5,
        BR_BEQ  = 4'd6,
        BR_BNE  = 4'd7,
        BR_BLT  = 4'd8,
        BR_BGE  = 4'd9,
        BR_BLTU = 4'd10,
        BR_BGEU = 4'd11
    } br_cond_t;

    typedef enum logic [3:0] {
        DIV_QUO = 4'd0,
        DIV_REM = 4'd1
    } div_op_t;

    // one op field, meaning picked by itype
    typedef union packed {
        alu_op_t  alu;
        br_cond_t br;
        div_op_t  div;
    } uop_op_u;

    typedef struct packed {
        itype_t  itype;
        uop_op_u op;
        logic    src2_imm;
        logic    usign;
    } uop_t;

endpackage

// File: design/pipe_pkg.sv
package pipe_pkg;

    import uop_pkg::*;

    // one issue slot as delivered by the register-read stage
    typedef struct packed {
        logic        en;
        uop_t        uop;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] pc_next;
    } issue_t;

    // write-back port, also the shape of each stage register
    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    // resolved branch for the predictor
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] pc;
        logic [31:0] target;
    } br_info_t;

endpackage

// File: design/exe_alu.sv
`timescale 1ns/1ps
module exe_alu import uop_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            // decode already places the upper immediate
            ALU_LUI:  result = b;
            default:  result = '0;
        endcase
    end

endmodule

// File: design/exe_branch.sv
`timescale 1ns/1ps
module exe_branch import uop_pkg::*, pipe_pkg::*; (
    input  logic        en,
    input  br_cond_t    cond,
    input  logic [31:0] pc,
    input  logic [31:0] pc_next,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] imm,
    output br_info_t    info,
    output logic        flush,
    output logic [31:0] link,
    output logic        link_en
);

    logic        cmp;
    logic        taken;
    logic [31:0] target;
    logic [31:0] seq_pc;
    logic [31:0] resolved;

    always_comb begin
        case (cond)
            BR_JIRL, BR_B, BR_BL: cmp = 1'b1;
            BR_BEQ:  cmp = a == b;
            BR_BNE:  cmp = a != b;
            BR_BLT:  cmp = $signed(a) < $signed(b);
            BR_BGE:  cmp = $signed(a) >= $signed(b);
            BR_BLTU: cmp = a < b;
            BR_BGEU: cmp = a >= b;
            default: cmp = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target   = (cond == BR_JIRL) ? a + imm : pc + imm;
    assign seq_pc   = pc + 32'd4;
    assign taken    = en && cmp;
    assign resolved = taken ? target : seq_pc;

    assign info.valid  = en;
    assign info.taken  = taken;
    assign info.pc     = pc;
    assign info.target = target;

    // mispredict whenever the fetch guess was wrong
    assign flush   = en && (resolved != pc_next);
    assign link    = seq_pc;
    assign link_en = en && (cond == BR_BL || cond == BR_JIRL);

endmodule

// File: design/exe_forward.sv
`timescale 1ns/1ps
module exe_forward import pipe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [4:0]      rj0,
    input  logic [4:0]      rk0,
    input  logic [4:0]      rj1,
    input  logic [4:0]      rk1,
    input  logic [XLEN-1:0] rf0_rj,
    input  logic [XLEN-1:0] rf0_rk,
    input  logic [XLEN-1:0] rf1_rj,
    input  logic [XLEN-1:0] rf1_rk,
    input  wb_t             ex1_0,
    input  wb_t             ex1_1,
    input  wb_t             wb0,
    input  wb_t             wb1,
    output logic [XLEN-1:0] op0a,
    output logic [XLEN-1:0] op0b,
    output logic [XLEN-1:0] op1a,
    output logic [XLEN-1:0] op1b
);

    // youngest producer wins
    function automatic logic [XLEN-1:0] pick(
        input logic [4:0]      src,
        input logic [XLEN-1:0] rf,
        input wb_t             e1,
        input wb_t             e0,
        input wb_t             w1,
        input wb_t             w0
    );
        logic [XLEN-1:0] val;
        if (src == 5'd0) begin
            val = '0;
        end else if (e1.en && e1.rd == src) begin
            val = e1.data;
        end else if (e0.en && e0.rd == src) begin
            val = e0.data;
        end else if (w1.en && w1.rd == src) begin
            val = w1.data;
        end else if (w0.en && w0.rd == src) begin
            val = w0.data;
        end else begin
            val = rf;
        end
        return val;
    endfunction

    assign op0a = pick(rj0, rf0_rj, ex1_1, ex1_0, wb1, wb0);
    assign op0b = pick(rk0, rf0_rk, ex1_1, ex1_0, wb1, wb0);
    assign op1a = pick(rj1, rf1_rj, ex1_1, ex1_0, wb1, wb0);
    assign op1b = pick(rk1, rf1_rk, ex1_1, ex1_0, wb1, wb0);

endmodule

// File: design/div_ctrl.sv
`timescale 1ns/1ps
module div_ctrl #(
    parameter int DIV_STEPS = 32
) (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic clear,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = RUN;
            RUN:     if (last) state_nxt = FINISH;
            FINISH:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign load  = (state == IDLE) && start;
    // counter sits at zero between divides
    assign clear = (state == IDLE);
    assign step  = (state == RUN);
    assign busy  = (state != IDLE);
    // result is final in FINISH
    assign done  = (state == FINISH);

    // the issue side must not start a divide while one is running
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn) start |-> !busy);

    // counter paces exactly DIV_STEPS steps before the result
    a_run_len: assert property (@(posedge clk) disable iff (!rstn)
        load |-> ##(DIV_STEPS + 1) done);

endmodule

// File: design/div_count.sv
`timescale 1ns/1ps
module div_count #(
    parameter int DIV_STEPS = 32
) (
    input  logic clk,
    input  logic rstn,
    input  logic clear,
    input  logic step,
    output logic last
);

    localparam int CW = $clog2(DIV_STEPS);
    localparam logic [CW-1:0] LAST_CNT = CW'(DIV_STEPS - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rstn || clear) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign last = (cnt == LAST_CNT);

endmodule

// File: design/div_datapath.sv
`timescale 1ns/1ps
module div_datapath import uop_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            load,
    input  logic            step,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    input  logic            usign,
    input  div_op_t         sel,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dsr;
    logic [XLEN-1:0] dvd_abs;
    logic [XLEN-1:0] dsr_abs;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;
    logic            neg_q;
    logic            neg_r;
    logic            dz;
    logic            want_rem;

    assign dvd_abs = (!usign && dividend[XLEN-1]) ? -dividend : dividend;
    assign dsr_abs = (!usign && divisor[XLEN-1]) ? -divisor : divisor;

    // next dividend bit enters the partial remainder
    assign shifted = {rem, quo[XLEN-1]};
    assign diff    = shifted - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (load) begin
            quo <= dvd_abs;
            rem <= '0;
            dsr <= dsr_abs;
        end else if (step) begin
            quo <= {quo[XLEN-2:0], ~diff[XLEN]};
            rem <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            dz       <= 1'b0;
            want_rem <= 1'b0;
        end else if (load) begin
            neg_q    <= !usign && (dividend[XLEN-1] ^ divisor[XLEN-1]);
            neg_r    <= !usign && dividend[XLEN-1];
            dz       <= (divisor == '0);
            want_rem <= (sel == DIV_REM);
        end
    end

    assign quo_fix = neg_q ? -quo : quo;
    // a zero divisor leaves |dividend| in rem, so the sign fix restores the dividend
    assign rem_fix = neg_r ? -rem : rem;
    assign result  = want_rem ? rem_fix : (dz ? '1 : quo_fix);

endmodule

// File: design/exe_top.sv
`timescale 1ns/1ps
module exe_top import uop_pkg::*, pipe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  issue_t          issue0,
    input  issue_t          issue1,
    input  logic [XLEN-1:0] rf0_rj,
    input  logic [XLEN-1:0] rf0_rk,
    input  logic [XLEN-1:0] rf1_rj,
    input  logic [XLEN-1:0] rf1_rk,
    output wb_t             wb0,
    output wb_t             wb1,
    output br_info_t        br,
    output logic            stall,
    output logic            flush
);

    localparam int DIV_STEPS = XLEN;

    wb_t             ex1_0;
    wb_t             ex1_1;
    logic [XLEN-1:0] op0a;
    logic [XLEN-1:0] op0b;
    logic [XLEN-1:0] op1a;
    logic [XLEN-1:0] op1b;
    logic [XLEN-1:0] alu0_b;
    logic [XLEN-1:0] alu1_b;
    logic [XLEN-1:0] alu0_res;
    logic [XLEN-1:0] alu1_res;
    logic            alu0_en;
    logic            alu1_en;
    logic            br_en;
    logic            div_start;
    logic [31:0]     link;
    logic            link_en;
    logic            div_load;
    logic            div_step;
    logic            div_clear;
    logic            div_last;
    logic            div_busy;
    logic            div_done;
    logic [XLEN-1:0] div_res;
    logic [4:0]      div_rd;

    assign stall = div_busy;

    // issue slots count only while the divider is idle
    assign alu0_en   = issue0.en && !stall && issue0.uop.itype == ITYPE_ALU;
    assign br_en     = issue0.en && !stall && issue0.uop.itype == ITYPE_BR;
    assign div_start = issue0.en && !stall && issue0.uop.itype == ITYPE_DIV;
    assign alu1_en   = issue1.en && !stall && issue1.uop.itype == ITYPE_ALU;

    assign alu0_b = issue0.uop.src2_imm ? issue0.imm : op0b;
    assign alu1_b = issue1.uop.src2_imm ? issue1.imm : op1b;

    exe_forward #(.XLEN(XLEN)) exe_forward_inst (
        .rj0    (issue0.rj),
        .rk0    (issue0.rk),
        .rj1    (issue1.rj),
        .rk1    (issue1.rk),
        .rf0_rj (rf0_rj),
        .rf0_rk (rf0_rk),
        .rf1_rj (rf1_rj),
        .rf1_rk (rf1_rk),
        .ex1_0  (ex1_0),
        .ex1_1  (ex1_1),
        .wb0    (wb0),
        .wb1    (wb1),
        .op0a   (op0a),
        .op0b   (op0b),
        .op1a   (op1a),
        .op1b   (op1b)
    );

    exe_alu #(.XLEN(XLEN)) exe_alu0_inst (
        .op     (issue0.uop.op.alu),
        .a      (op0a),
        .b      (alu0_b),
        .result (alu0_res)
    );

    exe_alu #(.XLEN(XLEN)) exe_alu1_inst (
        .op     (issue1.uop.op.alu),
        .a      (op1a),
        .b      (alu1_b),
        .result (alu1_res)
    );

    exe_branch exe_branch_inst (
        .en      (br_en),
        .cond    (issue0.uop.op.br),
        .pc      (issue0.pc),
        .pc_next (issue0.pc_next),
        .a       (op0a),
        .b       (op0b),
        .imm     (issue0.imm),
        .info    (br),
        .flush   (flush),
        .link    (link),
        .link_en (link_en)
    );

    div_ctrl #(.DIV_STEPS(DIV_STEPS)) div_ctrl_inst (
        .clk   (clk),
        .rstn  (rstn),
        .start (div_start),
        .last  (div_last),
        .load  (div_load),
        .step  (div_step),
        .clear (div_clear),
        .busy  (div_busy),
        .done  (div_done)
    );

    div_count #(.DIV_STEPS(DIV_STEPS)) div_count_inst (
        .clk   (clk),
        .rstn  (rstn),
        .clear (div_clear),
        .step  (div_step),
        .last  (div_last)
    );

    div_datapath #(.XLEN(XLEN)) div_datapath_inst (
        .clk      (clk),
        .rstn     (rstn),
        .load     (div_load),
        .step     (div_step),
        .dividend (op0a),
        .divisor  (op0b),
        .usign    (issue0.uop.usign),
        .sel      (issue0.uop.op.div),
        .result   (div_res)
    );

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_rd <= issue0.rd;
        end
    end

    // ex1 stage, slot 0 carries either the ALU result or the link value
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex1_0.en <= 1'b0;
            ex1_1.en <= 1'b0;
        end else begin
            ex1_0.en <= alu0_en || link_en;
            ex1_1.en <= alu1_en;
        end
        ex1_0.rd   <= issue0.rd;
        ex1_0.data <= link_en ? link : alu0_res;
        ex1_1.rd   <= issue1.rd;
        ex1_1.data <= alu1_res;
    end

    // ex1 slot 0 is a bubble whenever the divider finishes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb0.en <= 1'b0;
            wb1.en <= 1'b0;
        end else begin
            wb0.en <= div_done || ex1_0.en;
            wb1.en <= ex1_1.en;
        end
        wb0.rd   <= div_done ? div_rd : ex1_0.rd;
        wb0.data <= div_done ? div_res : ex1_0.data;
        wb1.rd   <= ex1_1.rd;
        wb1.data <= ex1_1.data;
    end

    a_slot1_alu: assert property (@(posedge clk) disable iff (!rstn)
        issue1.en |-> issue1.uop.itype == ITYPE_ALU);

    a_stall_len: assert property (@(posedge clk) disable iff (!rstn)
        $rose(stall) |-> ##(DIV_STEPS + 1) !stall);

endmodule

// File: dv/exe_tb.sv
`timescale 1ns/1ps
module exe_tb import uop_pkg::*, pipe_pkg::*; ();

    localparam int XLEN        = 32;
    localparam int DIV_STEPS   = XLEN;
    localparam int DIV_TIMEOUT = 2 * DIV_STEPS;

    logic        clk;
    logic        rstn;
    issue_t      issue0;
    issue_t      issue1;
    logic [31:0] rf0_rj;
    logic [31:0] rf0_rk;
    logic [31:0] rf1_rj;
    logic [31:0] rf1_rk;
    wb_t         wb0;
    wb_t         wb1;
    br_info_t    br;
    logic        stall;
    logic        flush;

    // arch holds the newest values and rf_mem only what has left write-back
    logic [31:0] arch [32];
    logic [31:0] rf_mem [32];
    string       names [$];
    issue_t      tab0 [$];
    issue_t      tab1 [$];
    wb_t         cur0;
    wb_t         cur1;
    wb_t         mid0;
    wb_t         mid1;
    wb_t         out0;
    wb_t         out1;
    wb_t         div_exp;
    logic        exp_valid;
    logic        exp_taken;
    logic        exp_flush;
    logic [31:0] exp_target;
    logic [31:0] exp_pc;

    exe_top #(.XLEN(XLEN)) exe_top_inst (
        .clk    (clk),
        .rstn   (rstn),
        .issue0 (issue0),
        .issue1 (issue1),
        .rf0_rj (rf0_rj),
        .rf0_rk (rf0_rk),
        .rf1_rj (rf1_rj),
        .rf1_rk (rf1_rk),
        .wb0    (wb0),
        .wb1    (wb1),
        .br     (br),
        .stall  (stall),
        .flush  (flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_stop($sformatf("Mismatch %s %s: expected %h actual %h",
                                name, field, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input string field,
                             input logic exp, input logic act);
        assert (act === exp) else begin
            fail_stop($sformatf("Mismatch %s %s: expected %b actual %b",
                                name, field, exp, act));
        end
    endtask

    function automatic issue_t alu_uop(input alu_op_t op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic [31:0] imm, input logic use_imm);
        issue_t u;
        u = '0;
        u.en           = 1'b1;
        u.uop.itype    = ITYPE_ALU;
        u.uop.op.alu   = op;
        u.uop.src2_imm = use_imm;
        u.rd           = rd;
        u.rj           = rj;
        u.rk           = rk;
        u.imm          = imm;
        return u;
    endfunction

    function automatic issue_t br_uop(input br_cond_t cond, input logic [4:0] rd,
                                      input logic [4:0] rj, input logic [4:0] rk,
                                      input logic [31:0] imm, input logic [31:0] pc,
                                      input logic [31:0] pc_next);
        issue_t u;
        u = '0;
        u.en        = 1'b1;
        u.uop.itype = ITYPE_BR;
        u.uop.op.br = cond;
        u.rd        = rd;
        u.rj        = rj;
        u.rk        = rk;
        u.imm       = imm;
        u.pc        = pc;
        u.pc_next   = pc_next;
        return u;
    endfunction

    function automatic issue_t div_uop(input div_op_t sel, input logic usign,
                                       input logic [4:0] rd, input logic [4:0] rj,
                                       input logic [4:0] rk);
        issue_t u;
        u = '0;
        u.en         = 1'b1;
        u.uop.itype  = ITYPE_DIV;
        u.uop.op.div = sel;
        u.uop.usign  = usign;
        u.rd         = rd;
        u.rj         = rj;
        u.rk         = rk;
        return u;
    endfunction

    task automatic add_entry(input string name, input issue_t i0, input issue_t i1);
        names.push_back(name);
        tab0.push_back(i0);
        tab1.push_back(i1);
    endtask

    // load two registers through lui on both slots
    task automatic set_regs(input string name, input logic [4:0] ra, input logic [31:0] va,
                            input logic [4:0] rb, input logic [31:0] vb);
        add_entry(name, alu_uop(ALU_LUI, ra, 5'd0, 5'd0, va, 1'b1),
                  alu_uop(ALU_LUI, rb, 5'd0, 5'd0, vb, 1'b1));
    endtask

    function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_LUI:  return b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic usign, input logic want_rem);
        int sa;
        int sb;
        sa = a;
        sb = b;
        if (b == 32'd0) begin
            return want_rem ? a : 32'hffff_ffff;
        end
        if (usign) begin
            return want_rem ? a % b : a / b;
        end
        return want_rem ? sa % sb : sa / sb;
    endfunction

    function automatic logic br_taken(input br_cond_t cond, input logic [31:0] a,
                                      input logic [31:0] b);
        case (cond)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            // jirl, b and bl always jump
            default: return 1'b1;
        endcase
    endfunction

    task automatic refresh_rf();
        rf0_rj = rf_mem[issue0.rj];
        rf0_rk = rf_mem[issue0.rk];
        rf1_rj = rf_mem[issue1.rj];
        rf1_rk = rf_mem[issue1.rk];
    endtask

    // expected outcome of one issue pair against the state before it
    task automatic predict(input issue_t i0, input issue_t i1);
        logic [31:0] a0;
        logic [31:0] b0;
        logic [31:0] a1;
        logic [31:0] b1;
        br_cond_t    cond;
        a0 = arch[i0.rj];
        b0 = arch[i0.rk];
        a1 = arch[i1.rj];
        b1 = arch[i1.rk];
        cond = i0.uop.op.br;
        cur0 = '0;
        cur1 = '0;
        div_exp = '0;
        exp_valid = 1'b0;
        exp_taken = 1'b0;
        exp_flush = 1'b0;
        exp_target = 32'd0;
        exp_pc = 32'd0;
        if (i0.en) begin
            case (i0.uop.itype)
                ITYPE_ALU: begin
                    cur0 = {1'b1, i0.rd,
                            alu_ref(i0.uop.op.alu, a0, i0.uop.src2_imm ? i0.imm : b0)};
                end
                ITYPE_BR: begin
                    exp_valid  = 1'b1;
                    exp_pc     = i0.pc;
                    exp_taken  = br_taken(cond, a0, b0);
                    exp_target = (cond == BR_JIRL) ? a0 + i0.imm : i0.pc + i0.imm;
                    exp_flush  = (exp_taken ? exp_target : i0.pc + 32'd4) != i0.pc_next;
                    if (cond == BR_BL || cond == BR_JIRL) begin
                        cur0 = {1'b1, i0.rd, i0.pc + 32'd4};
                    end
                end
                default: begin
                    div_exp = {1'b1, i0.rd,
                               div_ref(a0, b0, i0.uop.usign, i0.uop.op.div == DIV_REM)};
                end
            endcase
        end
        if (i1.en) begin
            cur1 = {1'b1, i1.rd, alu_ref(i1.uop.op.alu, a1, i1.uop.src2_imm ? i1.imm : b1)};
        end
        if (cur0.en && cur0.rd != 5'd0) arch[cur0.rd] = cur0.data;
        if (div_exp.en && div_exp.rd != 5'd0) arch[div_exp.rd] = div_exp.data;
        if (cur1.en && cur1.rd != 5'd0) arch[cur1.rd] = cur1.data;
    endtask

    // one clock edge moves every expected result a stage on
    task automatic advance();
        @(posedge clk);
        #1;
        if (out0.en && out0.rd != 5'd0) rf_mem[out0.rd] = out0.data;
        if (out1.en && out1.rd != 5'd0) rf_mem[out1.rd] = out1.data;
        out0 = mid0;
        out1 = mid1;
        mid0 = cur0;
        mid1 = cur1;
        cur0 = '0;
        cur1 = '0;
        refresh_rf();
    endtask

    task automatic check_wb(input string name);
        check_bit(name, "wb0.en", out0.en, wb0.en);
        check_bit(name, "wb1.en", out1.en, wb1.en);
        if (out0.en) begin
            check_val(name, "wb0.rd", {27'd0, out0.rd}, {27'd0, wb0.rd});
            check_val(name, "wb0.data", out0.data, wb0.data);
        end
        if (out1.en) begin
            check_val(name, "wb1.rd", {27'd0, out1.rd}, {27'd0, wb1.rd});
            check_val(name, "wb1.data", out1.data, wb1.data);
        end
    endtask

    task automatic check_branch(input string name);
        check_bit(name, "br.valid", exp_valid, br.valid);
        check_bit(name, "flush", exp_flush, flush);
        if (exp_valid) begin
            check_bit(name, "br.taken", exp_taken, br.taken);
            check_val(name, "br.pc", exp_pc, br.pc);
            check_val(name, "br.target", exp_target, br.target);
        end
    endtask

    // issue0 stays on the divide while slot 1 offers an ALU op that must be dropped
    task automatic run_divide(input string name);
        int n;
        n = 0;
        do begin
            advance();
            if (stall) begin
                n++;
                issue1 = alu_uop(ALU_ADD, 5'd7, 5'd8, 5'd0, 32'd1, 1'b1);
                refresh_rf();
            end else begin
                out0 = div_exp;
            end
            check_wb(name);
            if (n > DIV_TIMEOUT) begin
                fail_stop($sformatf("timeout: stall never fell during %s", name));
            end
        end while (stall);
        check_val(name, "stall cycles", DIV_STEPS + 1, n);
    endtask

    task automatic build_table();
        alu_op_t     op;
        br_cond_t    cond;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] pc;
        logic [31:0] dvd [6];
        logic [31:0] dsr [6];
        for (int k = 0; k <= 10; k++) begin
            op = alu_op_t'(k);
            add_entry($sformatf("alu_reg_imm_%s", op.name()),
                      alu_uop(op, 5'd8, 5'd10, 5'd11, $urandom(), 1'b0),
                      alu_uop(op, 5'd9, 5'd12, 5'd0, $urandom(), 1'b1));
            add_entry($sformatf("alu_imm_reg_%s", op.name()),
                      alu_uop(op, 5'd8, 5'd13, 5'd0, $urandom(), 1'b1),
                      alu_uop(op, 5'd9, 5'd10, 5'd12, $urandom(), 1'b0));
        end
        set_regs("fwd_set", 5'd3, $urandom(), 5'd4, $urandom());
        add_entry("fwd_ex1", alu_uop(ALU_ADD, 5'd5, 5'd3, 5'd4, 32'd0, 1'b0),
                  alu_uop(ALU_SUB, 5'd6, 5'd4, 5'd3, 32'd0, 1'b0));
        add_entry("fwd_ex1_wb", alu_uop(ALU_XOR, 5'd7, 5'd3, 5'd5, 32'd0, 1'b0),
                  alu_uop(ALU_OR, 5'd3, 5'd6, 5'd4, 32'd0, 1'b0));
        set_regs("fwd_same_rd", 5'd20, $urandom(), 5'd20, $urandom());
        add_entry("fwd_slot1_first", alu_uop(ALU_ADD, 5'd21, 5'd20, 5'd0, 32'd0, 1'b0),
                  alu_uop(ALU_ADD, 5'd22, 5'd20, 5'd20, 32'd0, 1'b0));
        add_entry("fwd_old", alu_uop(ALU_LUI, 5'd23, 5'd0, 5'd0, $urandom(), 1'b1), '0);
        add_entry("fwd_new", alu_uop(ALU_LUI, 5'd23, 5'd0, 5'd0, $urandom(), 1'b1), '0);
        add_entry("fwd_ex1_over_wb", alu_uop(ALU_ADD, 5'd24, 5'd23, 5'd0, 32'd0, 1'b0),
                  alu_uop(ALU_SUB, 5'd25, 5'd0, 5'd23, 32'd0, 1'b0));
        add_entry("write_r0", alu_uop(ALU_LUI, 5'd0, 5'd0, 5'd0, $urandom(), 1'b1), '0);
        add_entry("read_r0", alu_uop(ALU_OR, 5'd26, 5'd0, 5'd0, 32'd0, 1'b0),
                  alu_uop(ALU_ADD, 5'd27, 5'd0, 5'd0, 32'd5, 1'b1));
        set_regs("br_set", 5'd14, 32'd5, 5'd15, 32'hffff_fffd);
        pc = 32'h1c00_0100;
        // operand pairs (5, -3), (-3, 5) and (5, 5)
        for (int p = 0; p < 3; p++) begin
            ra = (p == 1) ? 5'd15 : 5'd14;
            rb = (p == 0) ? 5'd15 : 5'd14;
            for (int k = 3; k <= 11; k++) begin
                cond = br_cond_t'(k);
                add_entry($sformatf("br_%s_%0d", cond.name(), p),
                          br_uop(cond, 5'd1, ra, rb, 32'h40, pc,
                                 ((k + p) % 2 == 0) ? pc + 32'd4 : pc + 32'h40), '0);
                pc = pc + 32'h100;
            end
        end
        add_entry("br_jirl_hit", br_uop(BR_JIRL, 5'd2, 5'd14, 5'd0, 32'h40, pc, 32'h45), '0);
        add_entry("br_link_use", alu_uop(ALU_ADD, 5'd28, 5'd2, 5'd1, 32'd0, 1'b0), '0);
        dvd[0] = 32'd100;
        dsr[0] = 32'd7;
        dvd[1] = -32'd100;
        dsr[1] = 32'd7;
        dvd[2] = 32'd100;
        dsr[2] = -32'd7;
        dvd[3] = -32'd100;
        dsr[3] = -32'd7;
        dvd[4] = -32'd12345;
        dsr[4] = 32'd0;
        dvd[5] = $urandom();
        dsr[5] = $urandom() >> 20;
        for (int p = 0; p < 6; p++) begin
            set_regs($sformatf("div_set_%0d", p), 5'd16, dvd[p], 5'd17, dsr[p]);
            for (int k = 0; k < 4; k++) begin
                add_entry($sformatf("div_%0d_%s_%s", p, k[0] ? "rem" : "quo", k[1] ? "u" : "s"),
                          div_uop(k[0] ? DIV_REM : DIV_QUO, k[1], 5'd18, 5'd16, 5'd17), '0);
            end
        end
        add_entry("div_use", alu_uop(ALU_ADD, 5'd19, 5'd18, 5'd16, 32'd0, 1'b0), '0);
    endtask

    initial begin
        int i;
        rstn = 1'b0;
        issue0 = '0;
        issue1 = '0;
        rf0_rj = 32'd0;
        rf0_rk = 32'd0;
        rf1_rj = 32'd0;
        rf1_rk = 32'd0;
        cur0 = '0;
        cur1 = '0;
        mid0 = '0;
        mid1 = '0;
        out0 = '0;
        out1 = '0;
        void'($urandom(40));
        // r0 reads junk from the register file but the DUT must see zero
        arch[0] = 32'd0;
        rf_mem[0] = $urandom() | 32'd1;
        for (int r = 1; r < 32; r++) begin
            arch[r] = $urandom();
            rf_mem[r] = arch[r];
        end
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_bit("reset", "wb0.en", 1'b0, wb0.en);
        check_bit("reset", "wb1.en", 1'b0, wb1.en);
        check_bit("reset", "br.valid", 1'b0, br.valid);
        check_bit("reset", "flush", 1'b0, flush);
        check_bit("reset", "stall", 1'b0, stall);
        for (i = 0; i < names.size(); i++) begin
            issue0 = tab0[i];
            issue1 = tab1[i];
            refresh_rf();
            predict(tab0[i], tab1[i]);
            #2;
            check_branch(names[i]);
            if (tab0[i].en && tab0[i].uop.itype == ITYPE_DIV) begin
                run_divide(names[i]);
            end else begin
                advance();
                check_wb(names[i]);
            end
        end
        issue0 = '0;
        issue1 = '0;
        repeat (3) begin
            advance();
            check_wb("drain");
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: list.f
design/uop_pkg.sv
design/pipe_pkg.sv
design/exe_alu.sv
design/exe_branch.sv
design/exe_forward.sv
design/div_ctrl.sv
design/div_count.sv
design/div_datapath.sv
design/exe_top.sv
dv/exe_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module exe_tb -f list.f -o exe_sim
./obj_dir/exe_sim
